//--- common/mdll_pkg.sv
/*
 * jitter monitor shared definitions
 * counter, phase, FIFO and credit widths
 * typedefs for counts, phase codes and the output record
 */

package mdll_pkg;

	// ------------------------------
	// widths and depths
	// ------------------------------

	// counter width, window is 2**N_JIT_CNT cycles
	localparam int N_JIT_CNT = 6;
	// 16 sampling phases
	localparam int N_PHASE = 4;
	// record FIFO entries, power of two
	localparam int BUF_DEPTH = 8;
	// credits granted by the consumer at reset
	localparam int CREDIT_INIT = 4;

	// derived widths
	localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
	localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);
	localparam int CREDIT_W = $clog2(CREDIT_INIT + 1);

	// ------------------------------
	// types
	// ------------------------------

	// one point of the edge CDF
	typedef logic [N_JIT_CNT-1:0] cdf_cnt_t;
	// sampling phase code
	typedef logic [N_PHASE-1:0] phase_code_t;
	// FIFO pointer, occupancy and credit count
	typedef logic [BUF_PTR_W-1:0] buf_ptr_t;
	typedef logic [BUF_CNT_W-1:0] buf_cnt_t;
	typedef logic [CREDIT_W-1:0] credit_t;

	// record: phase in the upper bits, count below
	typedef struct packed {
		phase_code_t phase;
		cdf_cnt_t cdf;
	} jm_record_t;

endpackage

//--- jmeas/mdll_jmeas.sv
/*
 * windowed bang-bang counter
 * one CDF count and a done pulse per 2**N_JIT_CNT cycles
 */

`timescale 1ns/1ps

module mdll_jmeas (
	input logic clk_monp,
	input logic en_monitor,
	input logic jm_bb_out_pol,
	input logic jm_bb_out_mon,
	output mdll_pkg::cdf_cnt_t jm_cdf_out,
	output logic win_done
);

	import mdll_pkg::*;

	// ------------------------------
	// signals
	// ------------------------------

	// free-running window position
	logic [N_JIT_CNT-1:0] pulse_cntr_r;
	// late events in the current window
	cdf_cnt_t cntr_r;
	cdf_cnt_t cntr_nxt;
	// count latched at the window end
	cdf_cnt_t cdf_r;
	logic win_done_r;
	logic late;
	logic sample;

	// ------------------------------
	// combinational
	// ------------------------------

	// pol high: bit taken as is, pol low: inverted
	assign late = jm_bb_out_pol ? jm_bb_out_mon : ~jm_bb_out_mon;

	// last cycle of the window
	assign sample = &pulse_cntr_r;

	// restart at window end, the bit of that edge is discarded
	// saturate at all ones otherwise
	assign cntr_nxt = sample ? '0 :
		((&cntr_r) ? cntr_r : cntr_r + cdf_cnt_t'(late));

	// ------------------------------
	// registers
	// ------------------------------

	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			pulse_cntr_r <= '0;
			cntr_r <= '0;
		end else begin
			pulse_cntr_r <= pulse_cntr_r + 1'b1;
			cntr_r <= cntr_nxt;
		end
	end

	// count and done pulse both valid from the window-end edge
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			cdf_r <= '0;
			win_done_r <= 1'b0;
		end else begin
			win_done_r <= sample;
			if (sample) begin
				cdf_r <= cntr_r;
			end
		end
	end

	assign jm_cdf_out = cdf_r;
	assign win_done = win_done_r;

	// one done pulse per window, then a full window of silence
	property p_one_done_per_window;
		@(posedge clk_monp) disable iff (!en_monitor)
			win_done |=> (!win_done) [*(2**N_JIT_CNT - 1)];
	endproperty

	a_one_done_per_window: assert property (p_one_done_per_window)
		else $error("win_done twice within one window");

endmodule

//--- design/jm_phase_sweep.sv
/*
 * sampling phase sweep controller
 * phase code register stepped on each accepted record
 */

`timescale 1ns/1ps

module jm_phase_sweep (
	input logic clk_monp,
	input logic en_monitor,
	input logic rec_accept,
	output mdll_pkg::phase_code_t phase_code
);

	import mdll_pkg::*;

	// ------------------------------
	// phase register
	// ------------------------------

	phase_code_t phase_r;
	phase_code_t phase_nxt;

	// step by one per delivered window
	// wraps after the last phase, N_PHASE bits give modulo 16
	// a dropped window keeps the phase so it is measured again
	always_comb begin
		phase_nxt = phase_r;
		if (rec_accept) begin
			phase_nxt = phase_r + 1'b1;
		end
	end

	// the record written on this edge still carries phase_r
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			phase_r <= '0;
		end else begin
			phase_r <= phase_nxt;
		end
	end

	// phase code to the analog interpolator and the buffer
	assign phase_code = phase_r;

	// ------------------------------
	// checks
	// ------------------------------

	// no phase change without an accepted record the cycle before
	property p_phase_hold;
		@(posedge clk_monp) disable iff (!en_monitor)
			!$past(rec_accept) |-> $stable(phase_code);
	endproperty

	a_phase_hold: assert property (p_phase_hold)
		else $error("phase_code moved without rec_accept");

endmodule

//--- design/jm_cdf_buffer.sv
/*
 * record buffer for the jitter monitor
 * phase tagging, record FIFO, credit counter for the sends
 * sticky overrun flag on a dropped record
 */

`timescale 1ns/1ps

module jm_cdf_buffer (
	input logic clk_monp,
	input logic en_monitor,
	input logic win_done,
	input mdll_pkg::cdf_cnt_t cdf_in,
	input mdll_pkg::phase_code_t phase_code,
	output logic rec_accept,
	output logic out_valid,
	output mdll_pkg::jm_record_t out_rec,
	input logic credit_ret,
	output logic overrun
);

	import mdll_pkg::*;

	// ------------------------------
	// signals
	// ------------------------------

	jm_record_t mem [BUF_DEPTH];
	jm_record_t rec_in;
	buf_ptr_t wr_ptr_r;
	buf_ptr_t rd_ptr_r;
	buf_cnt_t count_r;
	credit_t credit_r;
	logic wr_pend_r;
	logic out_valid_r;
	logic overrun_r;
	logic room;
	logic push;
	logic pop;
	logic send_ok;

	// ------------------------------
	// write side
	// ------------------------------

	// write cycle is the one after win_done
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			wr_pend_r <= 1'b0;
		end else begin
			wr_pend_r <= win_done;
		end
	end

	// tag with the phase still in force on the write cycle
	assign rec_in = {phase_code, cdf_in};

	// entry leaving on the same edge frees a slot
	assign pop = out_valid_r;
	assign room = (count_r != buf_cnt_t'(BUF_DEPTH)) || pop;
	assign push = wr_pend_r && room;
	assign rec_accept = push;

	// payload storage
	always_ff @(posedge clk_monp) begin
		if (push) begin
			mem[wr_ptr_r] <= rec_in;
		end
	end

	// ------------------------------
	// read side and credits
	// ------------------------------

	// one send per credit, idle cycle between sends
	assign send_ok = (credit_r != '0) && (count_r != '0) && !out_valid_r;

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk_monp or negedge en_monitor) begin
		if (!en_monitor) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			count_r <= '0;
			credit_r <= credit_t'(CREDIT_INIT);
			out_valid_r <= 1'b0;
			overrun_r <= 1'b0;
		end else begin
			out_valid_r <= send_ok;
			if (push) begin
				wr_ptr_r <= wr_ptr_r + 1'b1;
			end
			if (pop) begin
				rd_ptr_r <= rd_ptr_r + 1'b1;
			end
			// occupancy
			case ({push, pop})
				2'b10: count_r <= count_r + 1'b1;
				2'b01: count_r <= count_r - 1'b1;
				default: count_r <= count_r;
			endcase
			// credit spent per send, returned one at a time
			case ({credit_ret, pop})
				2'b10: credit_r <= credit_r + 1'b1;
				2'b01: credit_r <= credit_r - 1'b1;
				default: credit_r <= credit_r;
			endcase
			// cleared by reset only
			if (wr_pend_r && !room) begin
				overrun_r <= 1'b1;
			end
		end
	end

	// head of the FIFO, popped at the end of the out_valid cycle
	assign out_rec = mem[rd_ptr_r];
	assign out_valid = out_valid_r;
	assign overrun = overrun_r;

	// ------------------------------
	// checks
	// ------------------------------

	// consumer never returns more than it was granted
	a_credit_max: assert property (@(posedge clk_monp) disable iff (!en_monitor)
		credit_r <= credit_t'(CREDIT_INIT))
		else $error("credit count above CREDIT_INIT");

	a_valid_not_empty: assert property (@(posedge clk_monp) disable iff (!en_monitor)
		out_valid |-> (count_r != '0))
		else $error("out_valid with an empty FIFO");

endmodule

//--- design/mdll_jmeas_top.sv
/*
 * jitter monitor top level
 * phase sweep, windowed counter and record buffer
 */

`timescale 1ns/1ps

module mdll_jmeas_top (
	input logic clk_monp,
	input logic en_monitor,
	input logic jm_bb_out_pol,
	input logic jm_bb_out_mon,
	input logic credit_ret,
	output mdll_pkg::phase_code_t phase_code,
	output logic out_valid,
	output mdll_pkg::jm_record_t out_rec,
	output logic overrun
);

	import mdll_pkg::*;

	// ------------------------------
	// stage links
	// ------------------------------

	cdf_cnt_t jm_cdf;
	logic win_done;
	logic rec_accept;

	// count stage
	mdll_jmeas u_jmeas (
		.clk_monp (clk_monp),
		.en_monitor (en_monitor),
		.jm_bb_out_pol (jm_bb_out_pol),
		.jm_bb_out_mon (jm_bb_out_mon),
		.jm_cdf_out (jm_cdf),
		.win_done (win_done)
	);

	// sweep stage, advanced by the buffer
	jm_phase_sweep u_sweep (
		.clk_monp (clk_monp),
		.en_monitor (en_monitor),
		.rec_accept (rec_accept),
		.phase_code (phase_code)
	);

	// buffer stage with credit output
	jm_cdf_buffer u_buffer (
		.clk_monp (clk_monp),
		.en_monitor (en_monitor),
		.win_done (win_done),
		.cdf_in (jm_cdf),
		.phase_code (phase_code),
		.rec_accept (rec_accept),
		.out_valid (out_valid),
		.out_rec (out_rec),
		.credit_ret (credit_ret),
		.overrun (overrun)
	);

endmodule

//--- tb/tb_clkgen.sv
/*
 * testbench clock and reset generator
 * 20 ns clk_monp, en_monitor low for 2 cycles
 */

`timescale 1ns/1ps

module tb_clkgen (
	output logic clk_monp,
	output logic en_monitor
);

	localparam int HALF_PERIOD = 10;
	localparam int RST_CYCLES = 2;

	// free-running clock, starts low
	initial begin
		clk_monp = 1'b0;
		forever #(HALF_PERIOD) clk_monp = ~clk_monp;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		en_monitor = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_monp);
		@(negedge clk_monp);
		en_monitor = 1'b1;
	end

endmodule

//--- tb/jm_checker.sv
/*
 * reference model and output checks for the jitter monitor
 * window counts, phase tags, FIFO mirror, credits, drops
 */

`timescale 1ns/1ps

module jm_checker (
	input logic clk_monp,
	input logic en_monitor,
	input logic jm_bb_out_pol,
	input logic jm_bb_out_mon,
	input logic credit_ret,
	input mdll_pkg::phase_code_t phase_code,
	input logic out_valid,
	input mdll_pkg::jm_record_t out_rec,
	input logic overrun,
	output int win_cnt,
	output int backlog,
	output int drops,
	output int err_cnt
);

	import mdll_pkg::*;

	localparam int WIN_LEN = 2**N_JIT_CNT;

	// ------------------------------
	// model state
	// ------------------------------

	jm_record_t exp_q[$];
	int edge_cnt;
	int late_cnt;
	int wr_wait;
	int credits;
	cdf_cnt_t win_cdf;
	phase_code_t exp_phase;
	phase_code_t last_phase;
	logic have_last;
	logic exp_overrun;

	task automatic print_mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		err_cnt++;
		$display("[FAIL] %s: expected %0d, actual %0d (t=%0t)",
			name, exp_v, act_v, $time);
	endtask

	task automatic note_error(input string msg);
		err_cnt++;
		$display("ERROR: %s (t=%0t)", msg, $time);
	endtask

	initial begin
		err_cnt = 0;
		drops = 0;
		win_cnt = 0;
		backlog = 0;
	end

	// outputs held in reset, sampled mid-cycle
	always @(negedge clk_monp) begin : reset_state
		if (!en_monitor) begin
			if (out_valid !== 1'b0) print_mismatch("reset out_valid", 0, out_valid);
			if (overrun !== 1'b0) print_mismatch("reset overrun", 0, overrun);
			if (phase_code !== '0) print_mismatch("reset phase_code", 0, phase_code);
		end
	end

	// all inputs read here hold their pre-edge values
	always @(posedge clk_monp) begin : model
		jm_record_t head;
		jm_record_t new_rec;
		if (!en_monitor) begin
			// model restarts with the DUT
			edge_cnt = 0;
			late_cnt = 0;
			wr_wait = 0;
			credits = CREDIT_INIT;
			exp_phase = '0;
			have_last = 1'b0;
			exp_overrun = 1'b0;
			exp_q.delete();
		end else begin
			edge_cnt++;
			// registered outputs against the model
			if (phase_code !== exp_phase) print_mismatch("phase sweep", exp_phase, phase_code);
			if (overrun !== exp_overrun) print_mismatch("overrun flag", exp_overrun, overrun);

			// ------------------------------
			// send side
			// ------------------------------
			if (out_valid === 1'b1) begin
				if (credits <= 0) note_error("out_valid while no credit was left");
				if (exp_q.size() == 0) begin
					note_error("out_valid with no record expected");
				end else begin
					head = exp_q.pop_front();
					if (out_rec.cdf !== head.cdf) begin
						print_mismatch("cdf count", head.cdf, out_rec.cdf);
					end
					if (out_rec.phase !== head.phase) begin
						print_mismatch("phase tag", head.phase, out_rec.phase);
					end
					// dropped phases are measured again so none is skipped
					if (have_last && out_rec.phase !== phase_code_t'(last_phase + 1'b1)) begin
						print_mismatch("phase step", phase_code_t'(last_phase + 1'b1),
							out_rec.phase);
					end
					last_phase = out_rec.phase;
					have_last = 1'b1;
				end
				credits--;
			end else if (out_valid !== 1'b0) begin
				note_error("out_valid is unknown");
			end
			if (credit_ret) credits++;

			// ------------------------------
			// write side two edges after the window end
			// ------------------------------
			if (wr_wait > 0) begin
				wr_wait--;
				if (wr_wait == 0) begin
					// pop above already freed its slot
					if (exp_q.size() < BUF_DEPTH) begin
						new_rec.phase = exp_phase;
						new_rec.cdf = win_cdf;
						exp_q.push_back(new_rec);
						exp_phase = exp_phase + 1'b1;
					end else begin
						drops++;
						exp_overrun = 1'b1;
					end
				end
			end

			// bit of the window end edge is discarded
			if (edge_cnt % WIN_LEN == 0) begin
				win_cdf = cdf_cnt_t'(late_cnt);
				late_cnt = 0;
				win_cnt++;
				wr_wait = 2;
			end else if (jm_bb_out_pol ? jm_bb_out_mon : !jm_bb_out_mon) begin
				late_cnt++;
			end
			backlog = exp_q.size() + ((wr_wait > 0) ? 1 : 0);
		end
	end

endmodule

//--- tb/tb_jmeas.sv
/*
 * testbench top for the jitter monitor
 * LFSR bang-bang stimulus, credit return with a stall
 * timeout, DUT and checker instances
 */

`timescale 1ns/1ps

module tb_jmeas;

	import mdll_pkg::*;

	localparam int WIN_LEN = 2**N_JIT_CNT;
	localparam int N_WIN = 36;
	// credits withheld over 16 windows, FIFO fills and drops
	localparam int STALL_START = 6 * WIN_LEN;
	localparam int STALL_END = 22 * WIN_LEN;
	localparam int TIMEOUT = 40 * WIN_LEN + 500;
	localparam logic [31:0] LFSR_SEED = 32'he0fe_77ed;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic clk_monp;
	logic en_monitor;
	logic jm_bb_out_pol;
	logic jm_bb_out_mon;
	logic credit_ret;
	phase_code_t phase_code;
	logic out_valid;
	jm_record_t out_rec;
	logic overrun;
	int win_cnt;
	int backlog;
	int drops;
	int chk_err;
	int tb_err;
	logic [31:0] lfsr;
	int cycle;
	int owed;
	int ret_wait;
	int run_cycles;
	phase_code_t last_phase_seen;

	tb_clkgen u_clkgen (
		.clk_monp (clk_monp),
		.en_monitor (en_monitor)
	);

	mdll_jmeas_top uut (
		.clk_monp (clk_monp),
		.en_monitor (en_monitor),
		.jm_bb_out_pol (jm_bb_out_pol),
		.jm_bb_out_mon (jm_bb_out_mon),
		.credit_ret (credit_ret),
		.phase_code (phase_code),
		.out_valid (out_valid),
		.out_rec (out_rec),
		.overrun (overrun)
	);

	jm_checker u_check (
		.clk_monp (clk_monp),
		.en_monitor (en_monitor),
		.jm_bb_out_pol (jm_bb_out_pol),
		.jm_bb_out_mon (jm_bb_out_mon),
		.credit_ret (credit_ret),
		.phase_code (phase_code),
		.out_valid (out_valid),
		.out_rec (out_rec),
		.overrun (overrun),
		.win_cnt (win_cnt),
		.backlog (backlog),
		.drops (drops),
		.err_cnt (chk_err)
	);

	// ------------------------------
	// random bits
	// ------------------------------

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// one LFSR step per bit
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// ------------------------------
	// stimulus and credit return
	// ------------------------------

	always @(posedge clk_monp) begin : drive
		logic [31:0] r;
		logic late_raw;
		logic pol_n;
		if (!en_monitor) begin
			jm_bb_out_mon <= 1'b0;
			credit_ret <= 1'b0;
			owed = 0;
			ret_wait = 0;
			cycle = 0;
		end else begin
			cycle++;
			// new sweep, flip polarity
			pol_n = jm_bb_out_pol;
			if (phase_code == '0 && last_phase_seen == '1) pol_n = ~pol_n;
			last_phase_seen = phase_code;
			// late chance grows with the phase, CDF-like counts
			take_bits(N_PHASE, r);
			late_raw = (r[N_PHASE-1:0] < phase_code);
			jm_bb_out_pol <= pol_n;
			jm_bb_out_mon <= pol_n ? late_raw : ~late_raw;

			// one credit owed per observed send
			credit_ret <= 1'b0;
			if (out_valid) owed++;
			if (ret_wait > 0) begin
				ret_wait--;
				if (ret_wait == 0) begin
					credit_ret <= 1'b1;
					owed--;
				end
			end else if (owed > 0 && !(cycle >= STALL_START && cycle < STALL_END)) begin
				take_bits(2, r);
				ret_wait = 1 + r[1:0];
			end
		end
	end

	// ------------------------------
	// run control
	// ------------------------------

	initial begin
		jm_bb_out_pol = 1'b1;
		jm_bb_out_mon = 1'b0;
		credit_ret = 1'b0;
		lfsr = LFSR_SEED;
		tb_err = 0;
		owed = 0;
		ret_wait = 0;
		cycle = 0;
		last_phase_seen = '0;
		run_cycles = 0;
		wait (en_monitor === 1'b1);
		// done when all windows are delivered, polled off the sampling edge
		while (!(win_cnt >= N_WIN && backlog == 0) && run_cycles < TIMEOUT) begin
			@(negedge clk_monp);
			run_cycles++;
		end
		if (run_cycles >= TIMEOUT) begin
			tb_err++;
			$display("timeout after %0d cycles, %0d windows seen, %0d records still expected",
				run_cycles, win_cnt, backlog);
		end else if (drops == 0) begin
			tb_err++;
			$display("the credit stall did not cause any dropped record");
		end
		$display("errors: checker %0d, testbench %0d, drops %0d", chk_err, tb_err, drops);
		if (chk_err == 0 && tb_err == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
common/mdll_pkg.sv
jmeas/mdll_jmeas.sv
design/jm_phase_sweep.sv
design/jm_cdf_buffer.sv
design/mdll_jmeas_top.sv
tb/tb_clkgen.sv
tb/jm_checker.sv
tb/tb_jmeas.sv

//--- Bender.yml
package:
  name: mdll_jmeas
  authors: []

sources:
  - common/mdll_pkg.sv
  - jmeas/mdll_jmeas.sv
  - design/jm_phase_sweep.sv
  - design/jm_cdf_buffer.sv
  - design/mdll_jmeas_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/jm_checker.sv
      - tb/tb_jmeas.sv
